/* include/ex_defs.svh */
// Execute stage constants: RV32 major opcodes and ALU funct3 codes.
`ifndef EX_DEFS_SVH
`define EX_DEFS_SVH

// Major opcodes, taken from instruction bits 6 to 2.
// Memory access.
`define EX_RV_OP_LOAD    5'b00000
`define EX_RV_OP_STORE   5'b01000

// Control transfer.
`define EX_RV_OP_BRANCH  5'b11000
`define EX_RV_OP_JAL     5'b11011
`define EX_RV_OP_JALR    5'b11001

// Register-register and register-immediate arithmetic.
// M extension shares the OP opcode, with funct7 bit 25 set.
`define EX_RV_OP_OP      5'b01100
`define EX_RV_OP_OP_IMM  5'b00100

// Upper immediates.
`define EX_RV_OP_LUI     5'b01101
`define EX_RV_OP_AUIPC   5'b00101

// ALU function codes, taken from funct3.
// ADD also covers SUB when funct7 bit 30 is set on OP.
`define EX_RV_ALU_ADD    3'b000
`define EX_RV_ALU_SLL    3'b001
`define EX_RV_ALU_SLT    3'b010
`define EX_RV_ALU_SLTU   3'b011
`define EX_RV_ALU_XOR    3'b100

// SRL also covers SRA when funct7 bit 30 is set.
`define EX_RV_ALU_SRL    3'b101
`define EX_RV_ALU_OR     3'b110
`define EX_RV_ALU_AND    3'b111

// Branch funct3 codes reuse the comparator.
// Bit 12 inverts the condition, bit 14 picks less-than over equal,
// and bit 13 picks an unsigned compare.

`endif

/* src/ex_pkg.sv */
// Execute stage types: data vectors and the ID/EX and EX/MEM pipeline structs.
`default_nettype none

package ex_pkg;

    // Data word of the integer datapath.
    typedef logic [31:0] word_t;

    // Instruction address; bit 0 is always zero and not stored.
    typedef logic [31:1] pc_t;

    // Raw instruction word.
    typedef logic [31:0] insn_t;

    // Trap cause code.
    typedef logic [3:0] cause_t;

    // Architectural register index.
    typedef logic [4:0] regidx_t;

    // What the decode stage hands to EX.
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        insn_t  insn;
        logic   use_rd;
        word_t  rs1_val;
        word_t  rs2_val;
        logic   branch;
        logic   branch_predict;
        logic   trap;
        cause_t cause;
    } id_ex_t;

    // What EX hands to the memory stage.
    typedef struct packed {
        logic   valid;
        pc_t    pc;
        insn_t  insn;
        logic   use_rd;
        // ALU result or memory address.
        word_t  result;
        word_t  store_data;
        logic   trap;
        cause_t cause;
    } ex_mem_t;

endpackage

`default_nettype wire

/* src/ex_mul.sv */
// Multiplier: full 64-bit product with per-operand signed or unsigned extension.
`timescale 1ns/1ps
`default_nettype none

module ex_mul (
    input  logic           lhs_unsigned,
    input  logic           rhs_unsigned,
    input  ex_pkg::word_t  lhs,
    input  ex_pkg::word_t  rhs,
    output logic [63:0]    product
);
    logic signed [32:0] lhs_ext;
    logic signed [32:0] rhs_ext;
    logic signed [63:0] full;

    // One extra bit holds the sign, or zero for unsigned operands.
    assign lhs_ext = {lhs[31] & ~lhs_unsigned, lhs};
    assign rhs_ext = {rhs[31] & ~rhs_unsigned, rhs};

    // Operands widen to 64 bits, so every product bit kept here is exact.
    assign full    = lhs_ext * rhs_ext;
    assign product = full;
endmodule

`default_nettype wire

/* src/ex_div.sv */
// Divider: combinational quotient and remainder with RISC-V corner-case rules.
`timescale 1ns/1ps
`default_nettype none

module ex_div (
    input  logic           is_unsigned,
    input  ex_pkg::word_t  dividend,
    input  ex_pkg::word_t  divisor,
    output ex_pkg::word_t  quotient,
    output ex_pkg::word_t  remainder
);
    import ex_pkg::*;

    logic div_zero;
    logic overflow;

    assign div_zero = (divisor == '0);
    // Only meaningful in the signed case.
    assign overflow = !is_unsigned && (dividend == 32'h8000_0000) && (divisor == '1);

    always_comb begin
        logic signed [31:0] s_quot;
        logic signed [31:0] s_rem;

        s_quot = '0;
        s_rem  = '0;
        if (div_zero) begin
            // Division by zero.
            quotient  = '1;
            remainder = dividend;
        end else if (overflow) begin
            // Most negative over minus one.
            quotient  = dividend;
            remainder = '0;
        end else if (is_unsigned) begin
            quotient  = dividend / divisor;
            remainder = dividend % divisor;
        end else begin
            // Truncates toward zero, as the ISA requires.
            s_quot    = $signed(dividend) / $signed(divisor);
            s_rem     = $signed(dividend) % $signed(divisor);
            quotient  = word_t'(s_quot);
            remainder = word_t'(s_rem);
        end
    end
endmodule

`default_nettype wire

/* src/ex_shift.sv */
// Barrel shifter for SLL, SRL and SRA.
`timescale 1ns/1ps
`default_nettype none

module ex_shift (
    input  logic           arith,
    input  logic           right,
    input  ex_pkg::word_t  value,
    input  ex_pkg::word_t  amount,
    output ex_pkg::word_t  shifted
);
    import ex_pkg::*;

    logic [4:0]         shamt;
    logic signed [31:0] sra_res;
    word_t              srl_res;
    word_t              sll_res;

    // Only the low five bits count on RV32.
    assign shamt   = amount[4:0];

    // Kept apart so the signed shift is not evaluated in an unsigned context.
    assign sra_res = $signed(value) >>> shamt;
    assign srl_res = value >> shamt;
    assign sll_res = value << shamt;

    assign shifted = !right ? sll_res : (arith ? word_t'(sra_res) : srl_res);
endmodule

`default_nettype wire

/* src/ex_stage.sv */
// Execute stage: ID/EX barrier register, ALU, multiply/divide and branch check.
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module ex_stage (
    input  logic             clk,
    input  logic             rst,
    input  logic             clear,
    input  logic             stall,
    input  ex_pkg::id_ex_t   d,
    output ex_pkg::ex_mem_t  q,
    output logic             branch_mispredict,
    output logic             ex_writes_rd,
    output logic             ex_valid,
    output ex_pkg::insn_t    ex_insn
);
    import ex_pkg::*;

    id_ex_t      r;
    logic [4:0]  opcode;
    logic [2:0]  funct3;

    // Barrier register holds its contents while stall is high.
    always_ff @(posedge clk) begin
        if (rst) begin
            r.valid <= 1'b0;
            r.trap  <= 1'b0;
        end else if (!stall) begin
            r <= d;
        end
    end

    assign opcode = r.insn[6:2];
    assign funct3 = r.insn[14:12];

    // Instruction class decode.
    logic is_op;
    logic is_mem;
    logic is_jump;
    logic is_branch;
    assign is_op     = (opcode == `EX_RV_OP_OP) || (opcode == `EX_RV_OP_OP_IMM);
    assign is_mem    = (opcode == `EX_RV_OP_LOAD) || (opcode == `EX_RV_OP_STORE);
    assign is_jump   = (opcode == `EX_RV_OP_JAL) || (opcode == `EX_RV_OP_JALR);
    assign is_branch = (opcode == `EX_RV_OP_BRANCH);

    // Immediates.
    word_t uimm;
    word_t imm_i;
    word_t imm_s;
    assign uimm  = {r.insn[31:12], 12'b0};
    assign imm_i = {{20{r.insn[31]}}, r.insn[31:20]};
    assign imm_s = {{20{r.insn[31]}}, r.insn[31:25], r.insn[11:7]};

    // Bit 5 separates OP, and BRANCH, from OP-IMM.
    word_t op_rhs;
    assign op_rhs = r.insn[5] ? r.rs2_val : imm_i;

    // Arithmetic units.
    logic [63:0] mul_res;
    word_t       div_res;
    word_t       rem_res;
    word_t       shift_res;
    logic        muldiv;
    assign muldiv = r.insn[25] && (opcode == `EX_RV_OP_OP);

    ex_mul u_mul (
        .lhs_unsigned (r.insn[13] && r.insn[12]),
        .rhs_unsigned (r.insn[13]),
        .lhs          (r.rs1_val),
        .rhs          (r.rs2_val),
        .product      (mul_res)
    );

    ex_div u_div (
        .is_unsigned (r.insn[12]),
        .dividend    (r.rs1_val),
        .divisor     (r.rs2_val),
        .quotient    (div_res),
        .remainder   (rem_res)
    );

    ex_shift u_shift (
        .arith   (r.insn[30]),
        .right   (r.insn[14]),
        .value   (r.rs1_val),
        .amount  (op_rhs),
        .shifted (shift_res)
    );

    // Comparisons subtract, and signed ones flip both top bits.
    logic cmp;
    logic flip_top;
    logic sub;
    assign cmp      = is_branch
                    || (is_op && ((funct3 == `EX_RV_ALU_SLT) || (funct3 == `EX_RV_ALU_SLTU)));
    assign flip_top = cmp && (r.insn[4] ? !r.insn[12] : !r.insn[13]);
    assign sub      = cmp || ((opcode == `EX_RV_OP_OP) && r.insn[30]);

    // Adder operand select.
    word_t add_lhs_sel;
    word_t add_rhs_sel;
    always_comb begin
        if (opcode == `EX_RV_OP_LOAD) begin
            add_lhs_sel = r.rs1_val;
            add_rhs_sel = imm_i;
        end else if (opcode == `EX_RV_OP_STORE) begin
            add_lhs_sel = r.rs1_val;
            add_rhs_sel = imm_s;
        end else if (is_jump) begin
            // Link address.
            add_lhs_sel = {r.pc, 1'b0};
            add_rhs_sel = 32'd4;
        end else begin
            add_lhs_sel = r.rs1_val;
            add_rhs_sel = op_rhs;
        end
    end

    word_t       add_lhs;
    word_t       add_rhs;
    logic [32:0] add_res;
    assign add_lhs = {add_lhs_sel[31] ^ flip_top, add_lhs_sel[30:0]};
    assign add_rhs = {add_rhs_sel[31] ^ flip_top ^ sub, add_rhs_sel[30:0] ^ {31{sub}}};
    assign add_res = {1'b0, add_lhs} + {1'b0, add_rhs} + {32'b0, sub};

    // No carry out of the subtraction means lhs < rhs.
    logic cmp_eq;
    logic cmp_lt;
    assign cmp_eq = (add_res[31:0] == '0);
    assign cmp_lt = !add_res[32];

    // Bit 12 inverts, bit 14 picks less-than.
    logic branch_taken;
    assign branch_taken      = r.insn[12] ^ (r.insn[14] ? cmp_lt : cmp_eq);
    assign branch_mispredict = r.valid && is_branch && (branch_taken != r.branch_predict);

    // Result mux.
    word_t result;
    always_comb begin
        if (is_op && muldiv) begin
            case (funct3)
                3'b000:  result = mul_res[31:0];
                3'b001,
                3'b010,
                3'b011:  result = mul_res[63:32];
                3'b100,
                3'b101:  result = div_res;
                default: result = rem_res;
            endcase
        end else if (is_op) begin
            case (funct3)
                `EX_RV_ALU_ADD:  result = add_res[31:0];
                `EX_RV_ALU_SLL:  result = shift_res;
                `EX_RV_ALU_SLT:  result = {31'b0, cmp_lt};
                `EX_RV_ALU_SLTU: result = {31'b0, cmp_lt};
                `EX_RV_ALU_XOR:  result = r.rs1_val ^ op_rhs;
                `EX_RV_ALU_SRL:  result = shift_res;
                `EX_RV_ALU_OR:   result = r.rs1_val | op_rhs;
                default:         result = r.rs1_val & op_rhs;
            endcase
        end else if (is_jump || is_mem) begin
            result = add_res[31:0];
        end else if (opcode == `EX_RV_OP_LUI) begin
            result = uimm;
        end else if (opcode == `EX_RV_OP_AUIPC) begin
            result = uimm + {r.pc, 1'b0};
        end else begin
            result = r.rs1_val;
        end
    end

    // Loads finish in MEM, so their rd value is not final here.
    logic final_in_ex;
    assign final_in_ex  = is_op || is_jump
                        || (opcode == `EX_RV_OP_LUI) || (opcode == `EX_RV_OP_AUIPC);
    assign ex_writes_rd = r.valid && r.use_rd && final_in_ex;

    // EX/MEM outputs; clear kills the instruction without touching the register.
    assign q.valid      = r.valid && !clear;
    assign q.pc         = r.pc;
    assign q.insn       = r.insn;
    assign q.use_rd     = r.use_rd;
    assign q.result     = result;
    assign q.store_data = r.rs2_val;
    assign q.trap       = r.trap && !clear;
    assign q.cause      = r.cause;

    assign ex_valid = r.valid;
    assign ex_insn  = r.insn;
endmodule

`default_nettype wire

/* src/ex_hazard.sv */
// Load-use hazard detector: stalls ID when it reads the rd of a load in EX.
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module ex_hazard (
    input  ex_pkg::insn_t  next_insn,
    input  ex_pkg::insn_t  ex_insn,
    input  logic           ex_valid,
    output logic           load_use_stall
);
    import ex_pkg::*;

    logic [4:0] next_op;
    regidx_t    rs1;
    regidx_t    rs2;
    regidx_t    ex_rd;
    logic       use_rs1;
    logic       use_rs2;
    logic       ex_load;

    assign next_op = next_insn[6:2];
    assign rs1     = next_insn[19:15];
    assign rs2     = next_insn[24:20];
    assign ex_rd   = ex_insn[11:7];

    // Source register use of the instruction in ID.
    assign use_rs1 = (next_op == `EX_RV_OP_OP) || (next_op == `EX_RV_OP_BRANCH)
                   || (next_op == `EX_RV_OP_OP_IMM) || (next_op == `EX_RV_OP_LOAD)
                   || (next_op == `EX_RV_OP_STORE);
    assign use_rs2 = (next_op == `EX_RV_OP_OP) || (next_op == `EX_RV_OP_BRANCH);

    // x0 never carries a hazard.
    assign ex_load = ex_valid && (ex_insn[6:2] == `EX_RV_OP_LOAD) && (ex_rd != '0);

    assign load_use_stall = ex_load
                          && ((use_rs1 && (rs1 == ex_rd)) || (use_rs2 && (rs2 == ex_rd)));
endmodule

`default_nettype wire

/* src/ex_unit.sv */
// Execute unit top: EX stage with its load-use hazard detector.
`timescale 1ns/1ps
`default_nettype none

module ex_unit (
    input  logic             clk,
    input  logic             rst,
    input  logic             stall,
    input  logic             clear,
    input  ex_pkg::id_ex_t   d,
    input  ex_pkg::insn_t    next_insn,
    output ex_pkg::ex_mem_t  q,
    output logic             branch_mispredict,
    output logic             ex_writes_rd,
    output logic             load_use_stall
);
    import ex_pkg::*;

    // Instruction held in the barrier register.
    insn_t ex_insn;
    logic  ex_valid;

    ex_stage u_stage (
        .clk               (clk),
        .rst               (rst),
        .clear             (clear),
        .stall             (stall),
        .d                 (d),
        .q                 (q),
        .branch_mispredict (branch_mispredict),
        .ex_writes_rd      (ex_writes_rd),
        .ex_valid          (ex_valid),
        .ex_insn           (ex_insn)
    );

    ex_hazard u_hazard (
        .next_insn      (next_insn),
        .ex_insn        (ex_insn),
        .ex_valid       (ex_valid),
        .load_use_stall (load_use_stall)
    );
endmodule

`default_nettype wire

/* verif/ex_unit_properties.sv */
// Execute unit properties: reset state, stall hold, clear masking and load-use stall.
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module ex_unit_properties (
    input logic             clk,
    input logic             rst,
    input logic             stall,
    input logic             clear,
    input ex_pkg::ex_mem_t  q,
    input logic             branch_mispredict,
    input logic             ex_writes_rd,
    input logic             load_use_stall
);
    // Set once the barrier register holds a captured instruction.
    logic loaded;

    always_ff @(posedge clk) begin
        if (rst) begin
            loaded <= 1'b0;
        end else if (!stall) begin
            loaded <= 1'b1;
        end
    end

    reset_quiet: assert property (@(posedge clk)
        rst |=> !q.valid && !q.trap && !branch_mispredict && !ex_writes_rd && !load_use_stall)
        else $error("EX output active in the cycle after reset");

    // Everything except valid and trap, which follow clear.
    stall_hold: assert property (@(posedge clk) disable iff (rst)
        (stall && loaded) |=> $stable({q.pc, q.insn, q.use_rd, q.result, q.store_data,
                                       q.cause, branch_mispredict, ex_writes_rd}))
        else $error("EX outputs changed while stalled");

    clear_kills: assert property (@(posedge clk) clear |-> !q.valid && !q.trap)
        else $error("q.valid or q.trap high while clear is high");

    stall_on_load: assert property (@(posedge clk)
        load_use_stall |-> (q.insn[6:2] == `EX_RV_OP_LOAD))
        else $error("load_use_stall raised without a load in EX");
endmodule

`default_nettype wire

/* verif/ex_unit_tb.sv */
// Execute unit testbench: LFSR random instructions checked against a reference model.
`timescale 1ns/1ps
`default_nettype none
`include "ex_defs.svh"

module ex_unit_tb;
    import ex_pkg::*;

    localparam int NUM_TXN    = 3000;
    localparam int MAX_CYCLES = 20000;

    logic    clk;
    logic    rst;
    logic    stall;
    logic    clear;
    id_ex_t  d;
    insn_t   next_insn;
    ex_mem_t q;
    logic    branch_mispredict;
    logic    ex_writes_rd;
    logic    load_use_stall;

    // Model copy of the barrier register.
    id_ex_t  m;
    logic    m_loaded;
    logic    consumed;
    word_t   lfsr;
    int      captured;
    int      cycles;

    ex_unit dut (
        .clk               (clk),
        .rst               (rst),
        .stall             (stall),
        .clear             (clear),
        .d                 (d),
        .next_insn         (next_insn),
        .q                 (q),
        .branch_mispredict (branch_mispredict),
        .ex_writes_rd      (ex_writes_rd),
        .load_use_stall    (load_use_stall)
    );

    bind ex_unit ex_unit_properties u_props (
        .clk               (clk),
        .rst               (rst),
        .stall             (stall),
        .clear             (clear),
        .q                 (q),
        .branch_mispredict (branch_mispredict),
        .ex_writes_rd      (ex_writes_rd),
        .load_use_stall    (load_use_stall)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Galois LFSR stepped once per bit taken.
    function automatic word_t lfsr_bits(input int n);
        word_t v;
        int    i;
        v = '0;
        for (i = 0; i < n; i++) begin
            v    = {v[30:0], lfsr[0]};
            lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
        end
        return v;
    endfunction

    // Corner values come often enough to hit the divider special cases.
    function automatic word_t pick_operand();
        logic [2:0] sel;
        sel = 3'(lfsr_bits(3));
        case (sel)
            3'd0:    return '0;
            3'd1:    return 32'h8000_0000;
            3'd2:    return '1;
            3'd3:    return 32'd1;
            3'd4:    return lfsr_bits(6);
            default: return lfsr_bits(32);
        endcase
    endfunction

    function automatic id_ex_t make_id_ex();
        id_ex_t     t;
        logic [3:0] pick;
        logic [4:0] op;
        logic [2:0] f3;
        t.valid = lfsr_bits(2) != 0;
        t.pc    = pc_t'(lfsr_bits(31));
        t.insn  = lfsr_bits(32);
        pick    = 4'(lfsr_bits(4));
        // OP takes the largest share; odd picks are M extension.
        case (pick)
            4'd0, 4'd1, 4'd2, 4'd3, 4'd4, 4'd5: op = `EX_RV_OP_OP;
            4'd6, 4'd7: op = `EX_RV_OP_OP_IMM;
            4'd8:       op = `EX_RV_OP_LOAD;
            4'd9:       op = `EX_RV_OP_STORE;
            4'd10, 4'd11: op = `EX_RV_OP_BRANCH;
            4'd12:      op = `EX_RV_OP_JAL;
            4'd13:      op = `EX_RV_OP_JALR;
            4'd14:      op = `EX_RV_OP_LUI;
            default:    op = `EX_RV_OP_AUIPC;
        endcase
        f3 = t.insn[14:12];
        // Branch funct3 010 and 011 are not defined.
        if (op == `EX_RV_OP_BRANCH && f3[2:1] == 2'b01) f3[1] = 1'b0;
        t.insn[14:12] = f3;
        t.insn[6:0]   = {op, 2'b11};
        t.insn[11:7]  = {2'b00, 3'(lfsr_bits(3))};
        if (op == `EX_RV_OP_OP) begin
            if (pick[0]) t.insn[31:25] = 7'b000_0001;
            else t.insn[31:25] = {1'b0, 1'(lfsr_bits(1)), 5'b0};
        end
        t.use_rd         = lfsr_bits(2) != 0;
        t.rs1_val        = pick_operand();
        t.rs2_val        = pick_operand();
        t.branch         = op == `EX_RV_OP_BRANCH;
        t.branch_predict = lfsr_bits(1) != 0;
        t.trap           = lfsr_bits(4) == 0;
        t.cause          = cause_t'(lfsr_bits(4));
        return t;
    endfunction

    function automatic insn_t make_next_insn();
        insn_t      t;
        logic [2:0] pick;
        t    = lfsr_bits(32);
        pick = 3'(lfsr_bits(3));
        case (pick)
            3'd0:    t[6:2] = `EX_RV_OP_OP;
            3'd1:    t[6:2] = `EX_RV_OP_BRANCH;
            3'd2:    t[6:2] = `EX_RV_OP_OP_IMM;
            3'd3:    t[6:2] = `EX_RV_OP_LOAD;
            3'd4:    t[6:2] = `EX_RV_OP_STORE;
            3'd5:    t[6:2] = `EX_RV_OP_LUI;
            3'd6:    t[6:2] = `EX_RV_OP_JAL;
            default: t[6:2] = 5'(lfsr_bits(5));
        endcase
        t[1:0]   = 2'b11;
        // Low register numbers so they often match the rd in EX.
        t[19:15] = {2'b00, 3'(lfsr_bits(3))};
        t[24:20] = {2'b00, 3'(lfsr_bits(3))};
        return t;
    endfunction

    function automatic word_t alu_model(input logic [2:0] f3, input logic alt,
                                        input logic is_reg, input word_t a, input word_t b);
        logic signed [31:0] sra;
        sra = $signed(a) >>> b[4:0];
        case (f3)
            `EX_RV_ALU_ADD:  return (is_reg && alt) ? a - b : a + b;
            `EX_RV_ALU_SLL:  return a << b[4:0];
            `EX_RV_ALU_SLT:  return {31'b0, $signed(a) < $signed(b)};
            `EX_RV_ALU_SLTU: return {31'b0, a < b};
            `EX_RV_ALU_XOR:  return a ^ b;
            `EX_RV_ALU_SRL:  return alt ? word_t'(sra) : a >> b[4:0];
            `EX_RV_ALU_OR:   return a | b;
            default:         return a & b;
        endcase
    endfunction

    function automatic word_t muldiv_model(input logic [2:0] f3, input word_t a, input word_t b);
        logic [63:0] a_s;
        logic [63:0] b_s;
        logic [63:0] prod;
        int          sa;
        int          sb;
        logic        ovf;
        a_s = {{32{a[31]}}, a};
        b_s = {{32{b[31]}}, b};
        sa  = a;
        sb  = b;
        ovf = (a == 32'h8000_0000) && (b == 32'hffff_ffff);
        // Low 64 bits of the extended product are exact.
        case (f3)
            3'd0, 3'd1: prod = a_s * b_s;
            3'd2:       prod = a_s * {32'b0, b};
            default:    prod = {32'b0, a} * {32'b0, b};
        endcase
        case (f3)
            3'd0:             return prod[31:0];
            3'd1, 3'd2, 3'd3: return prod[63:32];
            3'd4:             return (b == 0) ? '1 : (ovf ? a : word_t'(sa / sb));
            3'd5:             return (b == 0) ? '1 : a / b;
            3'd6:             return (b == 0) ? a : (ovf ? '0 : word_t'(sa % sb));
            default:          return (b == 0) ? a : a % b;
        endcase
    endfunction

    function automatic word_t expected_result(input id_ex_t r);
        word_t imm_i;
        word_t imm_s;
        word_t pc_byte;
        word_t uimm;
        imm_i   = {{20{r.insn[31]}}, r.insn[31:20]};
        imm_s   = {{20{r.insn[31]}}, r.insn[31:25], r.insn[11:7]};
        pc_byte = {r.pc, 1'b0};
        uimm    = {r.insn[31:12], 12'h000};
        case (r.insn[6:2])
            `EX_RV_OP_LOAD:                return r.rs1_val + imm_i;
            `EX_RV_OP_STORE:               return r.rs1_val + imm_s;
            `EX_RV_OP_JAL, `EX_RV_OP_JALR: return pc_byte + 32'd4;
            `EX_RV_OP_LUI:                 return uimm;
            `EX_RV_OP_AUIPC:               return pc_byte + uimm;
            `EX_RV_OP_OP: begin
                if (r.insn[25]) return muldiv_model(r.insn[14:12], r.rs1_val, r.rs2_val);
                return alu_model(r.insn[14:12], r.insn[30], 1'b1, r.rs1_val, r.rs2_val);
            end
            default: return alu_model(r.insn[14:12], r.insn[30], 1'b0, r.rs1_val, imm_i);
        endcase
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            $display("Mismatch at %0t: %s expected %h, got %h", $time, what, expected, actual);
            $display("Errors found");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic check_outputs();
        logic [4:0] op;
        logic [4:0] next_op;
        regidx_t    rd;
        logic       lt;
        logic       ltu;
        logic       taken;
        logic       writes;
        logic       reads_rd;
        op      = m.insn[6:2];
        next_op = next_insn[6:2];
        rd      = m.insn[11:7];
        lt      = $signed(m.rs1_val) < $signed(m.rs2_val);
        ltu     = m.rs1_val < m.rs2_val;
        case (m.insn[14:12])
            3'b000:  taken = m.rs1_val == m.rs2_val;
            3'b001:  taken = m.rs1_val != m.rs2_val;
            3'b100:  taken = lt;
            3'b101:  taken = !lt;
            3'b110:  taken = ltu;
            default: taken = !ltu;
        endcase
        writes   = m.use_rd && (op inside {`EX_RV_OP_OP, `EX_RV_OP_OP_IMM, `EX_RV_OP_LUI,
                                           `EX_RV_OP_AUIPC, `EX_RV_OP_JAL, `EX_RV_OP_JALR});
        // OP and BRANCH read rs2 as well.
        reads_rd = ((next_op inside {`EX_RV_OP_OP, `EX_RV_OP_BRANCH, `EX_RV_OP_OP_IMM,
                                     `EX_RV_OP_LOAD, `EX_RV_OP_STORE})
                    && next_insn[19:15] == rd)
                 || ((next_op inside {`EX_RV_OP_OP, `EX_RV_OP_BRANCH}) && next_insn[24:20] == rd);
        check_value(q.valid, m.valid && !clear, "q.valid");
        check_value(q.trap, m.trap && !clear, "q.trap");
        check_value(branch_mispredict,
                    m.valid && op == `EX_RV_OP_BRANCH && taken != m.branch_predict,
                    "branch_mispredict");
        check_value(ex_writes_rd, m.valid && writes, "ex_writes_rd");
        check_value(load_use_stall, m.valid && op == `EX_RV_OP_LOAD && rd != 0 && reads_rd,
                    "load_use_stall");
        if (m_loaded) begin
            check_value(q.pc, m.pc, "q.pc");
            check_value(q.insn, m.insn, "q.insn");
            check_value(q.use_rd, m.use_rd, "q.use_rd");
            check_value(q.store_data, m.rs2_val, "q.store_data");
            check_value(q.cause, m.cause, "q.cause");
            if (op != `EX_RV_OP_BRANCH) check_value(q.result, expected_result(m), "q.result");
        end
    endtask

    initial begin
        lfsr      = 32'h9245_bc4d;
        rst       = 1'b1;
        stall     = 1'b0;
        clear     = 1'b0;
        d         = '0;
        next_insn = '0;
        m         = '0;
        m_loaded  = 1'b0;
        consumed  = 1'b0;
        captured  = 0;
        cycles    = 0;
        repeat (8) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        check_outputs();
        while (captured < NUM_TXN && cycles < MAX_CYCLES) begin
            @(posedge clk);
            // Mirror the barrier register at this edge.
            consumed = 1'b0;
            if (!stall) begin
                m        = d;
                m_loaded = 1'b1;
                consumed = 1'b1;
                captured++;
            end
            // Front end holds d until the stage takes it.
            if (consumed) d <= make_id_ex();
            stall     <= lfsr_bits(3) == 0;
            clear     <= lfsr_bits(3) == 0;
            next_insn <= make_next_insn();
            @(negedge clk);
            check_outputs();
            cycles++;
        end
        if (captured >= NUM_TXN) begin
            $display("No errors");
            $finish;
        end else begin
            $display("Timeout: only %0d of %0d instructions entered EX in %0d cycles",
                     captured, NUM_TXN, cycles);
            $display("Errors found");
            $fatal(1, "run stopped on timeout");
        end
    end
endmodule

`default_nettype wire

/* ex_unit.f */
+incdir+include
src/ex_pkg.sv
src/ex_mul.sv
src/ex_div.sv
src/ex_shift.sv
src/ex_stage.sv
src/ex_hazard.sv
src/ex_unit.sv
verif/ex_unit_properties.sv
verif/ex_unit_tb.sv

/* Makefile */
# Verilator build and run for the execute unit testbench.
VERILATOR  ?= verilator
TOP        := ex_unit_tb
FILELIST   := ex_unit.f
OBJ_DIR    := obj_dir
SIM_FLAGS  := --binary --timing --assert -Wno-fatal
LINT_FLAGS := --lint-only --timing -Wall
SOURCES    := $(wildcard src/*.sv verif/*.sv include/*.svh)

.PHONY: all run lint clean

all: run

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(OBJ_DIR)/V$(TOP)
	./$(OBJ_DIR)/V$(TOP)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)
